// File: design/decodedInstPkg.sv
// Decoded instruction packet
`default_nettype none

package decodedInstPkg;

  // field widths of one decoded instruction
  localparam int unsigned PC_W = 32;
  localparam int unsigned OPCODE_W = 8;
  // architectural register specifier width
  localparam int unsigned REG_W = 5;
  localparam int unsigned IMM_W = 16;

  // one decoded instruction as it leaves decode and waits in the queue
  // the fields add up to 76 bits, pc sits in the most significant bits
  typedef struct packed {
    // program counter of the instruction
    logic [PC_W-1:0] pc;
    logic [OPCODE_W-1:0] opcode;
    // source and destination register specifiers
    logic [REG_W-1:0] src1;
    logic [REG_W-1:0] src2;
    logic [REG_W-1:0] dest;
    // sign handling of the immediate is left to the consumer
    logic [IMM_W-1:0] immediate;
    // set for any control transfer, this is what the dispatch window counts
    logic isBranch;
    // kind of control transfer, meaningful only when isBranch is set
    logic [1:0] ctiKind;
    // load or store kind, zero for non-memory instructions
    logic [1:0] ldstKind;
  } decodedInst_t;

endpackage

`default_nettype wire

// File: design/fetchQueuePkg.sv
// Fetch queue geometry and groups
`default_nettype none

package fetchQueuePkg;

  // number of entries in the circular buffer and the pointer width
  localparam int unsigned QUEUE_DEPTH = 32;
  localparam int unsigned QUEUE_LOG = 5;

  // slots offered by decode per cycle and entries taken by rename per dispatch
  localparam int unsigned FETCH_WIDTH = 8;
  localparam int unsigned DISPATCH_WIDTH = 4;

  // a dispatch group holds at most four branches, so three bits suffice
  localparam int unsigned BRANCH_CNT_W = 3;

  // fetch stalls once the count is above this level, since a full
  // group of eight might not fit any more
  localparam int unsigned STALL_LEVEL = QUEUE_DEPTH - FETCH_WIDTH;

  // counts of valid slots in one group range from zero to eight
  localparam int unsigned SLOT_CNT_W = $clog2(FETCH_WIDTH + 1);

  // an entry index into the circular buffer, wrap-around comes from truncation
  typedef logic [QUEUE_LOG-1:0] queueAddr_t;
  // occupancy needs one extra bit so that a full queue is distinct from empty
  typedef logic [QUEUE_LOG:0] queueCount_t;
  typedef logic [SLOT_CNT_W-1:0] slotCount_t;

  // one fetch group as offered by decode
  // the valid slots may be sparse, slot 0 is the oldest
  typedef struct packed {
    logic [FETCH_WIDTH-1:0] slotValid;
    decodedInstPkg::decodedInst_t [FETCH_WIDTH-1:0] slot;
  } fetchGroup_t;

  // four entries handed to rename in age order, entry 0 is the oldest
  typedef struct packed {
    decodedInstPkg::decodedInst_t [DISPATCH_WIDTH-1:0] entry;
  } dispatchGroup_t;

endpackage

`default_nettype wire

// File: design/queueStorage.sv
// Queue entry storage
`timescale 1ns/1ps
`default_nettype none

module queueStorage (
  input  wire logic clk,
  input  wire logic rst_i,
  // one enable and one compacted address per fetch slot
  input  wire logic [fetchQueuePkg::FETCH_WIDTH-1:0] wrEn_i,
  input  wire fetchQueuePkg::queueAddr_t [fetchQueuePkg::FETCH_WIDTH-1:0] wrAddr_i,
  input  wire decodedInstPkg::decodedInst_t [fetchQueuePkg::FETCH_WIDTH-1:0] wrData_i,
  // four read addresses, head first
  input  wire fetchQueuePkg::queueAddr_t [fetchQueuePkg::DISPATCH_WIDTH-1:0] rdAddr_i,
  output fetchQueuePkg::dispatchGroup_t rdData_o
);

  import decodedInstPkg::*;
  import fetchQueuePkg::*;

  // the circular buffer itself, indexed by the head and tail pointers
  decodedInst_t entryMem [QUEUE_DEPTH];

  // eight write ports land in one cycle
  // reset clears every entry so that the dispatch window reads zeros and the
  // branch count starts at zero, a flush only moves the pointers
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int e = 0; e < QUEUE_DEPTH; e++) begin
        entryMem[e] <= '0;
      end
    end else begin
      // compacted addresses are distinct, so the order of ports does not matter
      for (int s = 0; s < FETCH_WIDTH; s++) begin
        if (wrEn_i[s]) begin
          entryMem[wrAddr_i[s]] <= wrData_i[s];
        end
      end
    end
  end

  // four asynchronous read ports
  // an entry written at an edge is visible on these ports right after it
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      rdData_o.entry[r] = entryMem[rdAddr_i[r]];
    end
  end

  // the pointer logic must never aim two enabled ports at one entry,
  // otherwise one of the two instructions would silently be lost
  for (genvar a = 0; a < FETCH_WIDTH; a++) begin : g_wrPortA
    for (genvar b = a + 1; b < FETCH_WIDTH; b++) begin : g_wrPortB
      wrAddrDistinct : assert property (
        @(posedge clk) disable iff (rst_i)
        (wrEn_i[a] && wrEn_i[b]) |-> (wrAddr_i[a] != wrAddr_i[b])
      ) else $error("write ports %0d and %0d share address %0d", a, b, wrAddr_i[a]);
    end
  end

endmodule

`default_nettype wire

// File: design/queuePointers.sv
// Queue pointers and occupancy
`timescale 1ns/1ps
`default_nettype none

module queuePointers (
  input  wire logic clk,
  input  wire logic rst_i,
  // misprediction flush from branch resolution
  input  wire logic flush_i,
  // back-pressure from rename
  input  wire logic stall_i,
  input  wire logic decodeReady_i,
  input  wire logic [fetchQueuePkg::FETCH_WIDTH-1:0] slotValid_i,
  output fetchQueuePkg::queueAddr_t [fetchQueuePkg::FETCH_WIDTH-1:0] wrAddr_o,
  output logic [fetchQueuePkg::FETCH_WIDTH-1:0] wrEn_o,
  output fetchQueuePkg::queueAddr_t headPtr_o,
  output logic dispatch_o,
  output logic stallFetch_o,
  output logic instBufferReady_o
);

  import fetchQueuePkg::*;

  // tail is the next free entry, head is the oldest waiting entry
  queueAddr_t tailPtr;
  queueAddr_t headPtr;
  // number of entries waiting between head and tail
  queueCount_t instCount;

  // per slot offset from the tail, equal to the number of valid slots below it
  slotCount_t [FETCH_WIDTH-1:0] slotOffset;
  // number of valid slots in the offered group
  slotCount_t validCnt;
  // the group is taken at this edge
  logic accept;
  // number of entries that actually enter at this edge
  slotCount_t writeCnt;
  queueCount_t countNext;

  // prefix count over the slot mask
  // this is what squeezes out the holes of a sparse group
  always_comb begin
    slotCount_t running;
    running = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotOffset[s] = running;
      running = running + slotCount_t'(slotValid_i[s]);
    end
    validCnt = running;
  end

  // flags come straight from the count and the inputs of this cycle
  assign stallFetch_o = (instCount > queueCount_t'(STALL_LEVEL));
  assign instBufferReady_o = (instCount >= queueCount_t'(DISPATCH_WIDTH));
  // rename takes all four entries or none
  assign dispatch_o = instBufferReady_o && !stall_i;

  // a group offered while fetch is stalled is dropped and has to be held
  assign accept = decodeReady_i && !stallFetch_o;
  assign writeCnt = accept ? validCnt : '0;

  // compacted write addresses, wrapping through the low pointer bits
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      wrEn_o[s] = accept && slotValid_i[s];
      wrAddr_o[s] = tailPtr + queueAddr_t'(slotOffset[s]);
    end
  end

  // the count moves by the entries written minus four on a dispatch
  always_comb begin
    countNext = instCount + queueCount_t'(writeCnt);
    if (dispatch_o) begin
      countNext = countNext - queueCount_t'(DISPATCH_WIDTH);
    end
  end

  // flush empties the queue by clearing the pointers only
  // and wins over a write or a dispatch at the same edge
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      tailPtr <= '0;
      headPtr <= '0;
      instCount <= '0;
    end else begin
      tailPtr <= tailPtr + queueAddr_t'(writeCnt);
      if (dispatch_o) begin
        headPtr <= headPtr + queueAddr_t'(DISPATCH_WIDTH);
      end
      instCount <= countNext;
    end
  end

  assign headPtr_o = headPtr;

  // the stall level leaves room for one full group, so the count can
  // never run past the depth
  countInRange : assert property (
    @(posedge clk) disable iff (rst_i)
    instCount <= queueCount_t'(QUEUE_DEPTH)
  ) else $error("occupancy %0d exceeds the depth", instCount);

  // head, tail and count have to agree, except when full where the
  // pointers meet just as they do when empty
  pointersMatchCount : assert property (
    @(posedge clk) disable iff (rst_i)
    (instCount < queueCount_t'(QUEUE_DEPTH)) |->
      (queueAddr_t'(tailPtr - headPtr) == instCount[QUEUE_LOG-1:0])
  ) else $error("tail %0d head %0d disagree with count %0d", tailPtr, headPtr, instCount);

endmodule

`default_nettype wire

// File: design/dispatchWindow.sv
// Dispatch window
`timescale 1ns/1ps
`default_nettype none

module dispatchWindow (
  // oldest waiting entry
  input  wire fetchQueuePkg::queueAddr_t headPtr_i,
  // storage words read at rdAddr_o
  input  wire fetchQueuePkg::dispatchGroup_t rdData_i,
  output fetchQueuePkg::queueAddr_t [fetchQueuePkg::DISPATCH_WIDTH-1:0] rdAddr_o,
  output fetchQueuePkg::dispatchGroup_t dispatchGroup_o,
  output logic [fetchQueuePkg::BRANCH_CNT_W-1:0] branchCount_o
);

  import decodedInstPkg::*;
  import fetchQueuePkg::*;

  // four consecutive entries starting at the head
  // the depth is a power of two, so dropping the carry wraps the address
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      rdAddr_o[r] = headPtr_i + queueAddr_t'(r);
    end
  end

  // read port 0 faces the head, so the group is already oldest first
  assign dispatchGroup_o = rdData_i;

  // rename uses the number of branches to reserve checkpoints
  // the sum only means something while the queue is ready,
  // after reset it reads cleared entries and so stays at zero
  always_comb begin
    decodedInst_t headEntry;
    headEntry = '0;
    branchCount_o = '0;
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      headEntry = rdData_i.entry[r];
      branchCount_o = branchCount_o + BRANCH_CNT_W'(headEntry.isBranch);
    end
  end

endmodule

`default_nettype wire

// File: design/instBuffer.sv
// Fetch to dispatch instruction buffer
`timescale 1ns/1ps
`default_nettype none

module instBuffer (
  input  wire logic clk,
  input  wire logic rst_i,
  input  wire logic flush_i,
  input  wire logic stall_i,
  input  wire logic decodeReady_i,
  input  wire fetchQueuePkg::fetchGroup_t fetchGroup_i,
  output logic stallFetch_o,
  output logic instBufferReady_o,
  output fetchQueuePkg::dispatchGroup_t dispatchGroup_o,
  output logic [fetchQueuePkg::BRANCH_CNT_W-1:0] branchCount_o
);

  import fetchQueuePkg::*;

  // write side, from the pointer logic into storage
  logic [FETCH_WIDTH-1:0] wrEn;
  queueAddr_t [FETCH_WIDTH-1:0] wrAddr;
  // read side, head pointer out to the window and back through storage
  queueAddr_t headPtr;
  queueAddr_t [DISPATCH_WIDTH-1:0] rdAddr;
  dispatchGroup_t rdData;

  // the dispatch pulse only steers the head and the count inside
  queuePointers u_queuePointers (
    .clk              (clk),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .stall_i          (stall_i),
    .decodeReady_i    (decodeReady_i),
    .slotValid_i      (fetchGroup_i.slotValid),
    .wrAddr_o         (wrAddr),
    .wrEn_o           (wrEn),
    .headPtr_o        (headPtr),
    .dispatch_o       (),
    .stallFetch_o     (stallFetch_o),
    .instBufferReady_o(instBufferReady_o)
  );

  // storage is cleared by reset only, not by flush
  queueStorage u_queueStorage (
    .clk     (clk),
    .rst_i   (rst_i),
    .wrEn_i  (wrEn),
    .wrAddr_i(wrAddr),
    .wrData_i(fetchGroup_i.slot),
    .rdAddr_i(rdAddr),
    .rdData_o(rdData)
  );

  dispatchWindow u_dispatchWindow (
    .headPtr_i      (headPtr),
    .rdData_i       (rdData),
    .rdAddr_o       (rdAddr),
    .dispatchGroup_o(dispatchGroup_o),
    .branchCount_o  (branchCount_o)
  );

endmodule

`default_nettype wire

// File: verification/tbCheck.svh
// Testbench checking helpers

`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

  // one comparison word, wide enough for a whole dispatch group
  localparam int unsigned CMP_W = 320;
  typedef logic [CMP_W-1:0] cmpWord_t;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11, seeded with 11
  logic [15:0] lfsrState = 16'd11;

  int checkCount = 0;
  int errorCount = 0;
  // errors already counted when the running test began
  int errorsBefore = 0;
  string testName = "none";

  // one step of the LFSR gives one random bit
  function automatic logic lfsrStep();
    logic feedback;
    feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
  endfunction

  // n random bits, right aligned, the LFSR steps once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsrStep()};
    end
    return val;
  endfunction

  task automatic checkValue(input string label, input cmpWord_t expectedVal,
                            input cmpWord_t actualVal);
    checkCount++;
    if (expectedVal !== actualVal) begin
      errorCount++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h",
               testName, label, expectedVal, actualVal);
    end
  endtask

  // a flag that never came counts as an error of its own
  task automatic noteTimeout(input string what);
    errorCount++;
    $display("Timeout in %s: %s", testName, what);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    errorsBefore = errorCount;
  endtask

  task automatic reportTest();
    $display("test %s finished with %0d errors", testName, errorCount - errorsBefore);
  endtask

`endif

// File: verification/instBufferTb.sv
// Instruction buffer testbench
`timescale 1ns/1ps
`default_nettype none

module instBufferTb;

  import decodedInstPkg::*;
  import fetchQueuePkg::*;

  `include "tbCheck.svh"

  // what the DUT should show after one edge
  typedef struct packed {
    logic [QUEUE_LOG:0] count;
    logic ready;
    logic stallFetch;
    dispatchGroup_t group;
    logic [BRANCH_CNT_W-1:0] branchCount;
  } expect_t;

  logic clk;
  logic rst_i;
  logic flush_i;
  logic stall_i;
  logic decodeReady_i;
  fetchGroup_t fetchGroup;
  logic stallFetch_o;
  logic instBufferReady_o;
  dispatchGroup_t dispatchGroup_o;
  logic [BRANCH_CNT_W-1:0] branchCount_o;

  // model of the queue contents, oldest entry at index 0
  decodedInst_t modelQ[$];
  // expectation for the state after the most recent edge
  expect_t lastExpect;
  // program counter handed to the next valid slot, so order can be checked
  logic [31:0] seqNum;

  instBuffer i_dut (
    .clk              (clk),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .stall_i          (stall_i),
    .decodeReady_i    (decodeReady_i),
    .fetchGroup_i     (fetchGroup),
    .stallFetch_o     (stallFetch_o),
    .instBufferReady_o(instBufferReady_o),
    .dispatchGroup_o  (dispatchGroup_o),
    .branchCount_o    (branchCount_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // one instruction with random fields and the given pc
  function automatic decodedInst_t makeInst(input logic [31:0] pc);
    decodedInst_t inst;
    logic [31:0] rndA;
    logic [31:0] rndB;
    rndA = randBits(28);
    rndB = randBits(16);
    inst.pc = pc;
    inst.opcode = rndA[7:0];
    inst.src1 = rndA[12:8];
    inst.src2 = rndA[17:13];
    inst.dest = rndA[22:18];
    inst.ctiKind = rndA[24:23];
    inst.ldstKind = rndA[26:25];
    inst.isBranch = rndA[27];
    inst.immediate = rndB[15:0];
    return inst;
  endfunction

  function automatic fetchGroup_t makeGroup(input logic [FETCH_WIDTH-1:0] mask);
    fetchGroup_t grp;
    grp.slotValid = mask;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (mask[s]) begin
        grp.slot[s] = makeInst(seqNum);
        seqNum = seqNum + 32'd1;
      end else begin
        // holes carry junk that must never show up in a dispatch group
        grp.slot[s] = makeInst(32'hBAD0_0000 + 32'(s));
      end
    end
    return grp;
  endfunction

  // reference model of one edge, it updates the model queue and
  // returns what the outputs should show afterwards
  function automatic expect_t expectedGroup(input logic rst, input logic flush,
      input logic hold, input logic offer, input fetchGroup_t grp);
    expect_t res;
    decodedInst_t entry;
    int occupancy;
    res = '0;
    occupancy = modelQ.size();
    if (rst || flush) begin
      modelQ.delete();
    end else begin
      // the four oldest leave, so popping before the append is equivalent
      if (occupancy >= DISPATCH_WIDTH && !hold) begin
        for (int r = 0; r < DISPATCH_WIDTH; r++) begin
          void'(modelQ.pop_front());
        end
      end
      // fetch is stalled above the level, and then the group is dropped
      if (offer && occupancy <= STALL_LEVEL) begin
        for (int s = 0; s < FETCH_WIDTH; s++) begin
          if (grp.slotValid[s]) begin
            modelQ.push_back(grp.slot[s]);
          end
        end
      end
    end
    occupancy = modelQ.size();
    res.count = (QUEUE_LOG + 1)'(occupancy);
    res.ready = (occupancy >= DISPATCH_WIDTH);
    res.stallFetch = (occupancy > STALL_LEVEL);
    if (res.ready) begin
      for (int r = 0; r < DISPATCH_WIDTH; r++) begin
        entry = modelQ[r];
        res.group.entry[r] = entry;
        res.branchCount = res.branchCount + BRANCH_CNT_W'(entry.isBranch);
      end
    end
    return res;
  endfunction

  // inputs are sampled at the edge and the outputs compared half a cycle later
  always @(posedge clk) begin : compareOutputs
    expect_t expNow;
    expNow = expectedGroup(rst_i, flush_i, stall_i, decodeReady_i, fetchGroup);
    lastExpect = expNow;
    @(negedge clk);
    checkValue("instBufferReady_o", cmpWord_t'(expNow.ready), cmpWord_t'(instBufferReady_o));
    checkValue("stallFetch_o", cmpWord_t'(expNow.stallFetch), cmpWord_t'(stallFetch_o));
    // the group and the branch count only mean something while ready
    if (expNow.ready) begin
      checkValue("dispatchGroup_o", cmpWord_t'(expNow.group), cmpWord_t'(dispatchGroup_o));
      checkValue("branchCount_o", cmpWord_t'(expNow.branchCount), cmpWord_t'(branchCount_o));
    end
  end

  // one cycle of stimulus, applied shortly after the rising edge
  task automatic driveCycle(input logic [FETCH_WIDTH-1:0] mask, input logic offer,
                            input logic hold, input logic flush);
    @(posedge clk);
    #2;
    fetchGroup = makeGroup(mask);
    decodeReady_i = offer;
    stall_i = hold;
    flush_i = flush;
  endtask

  initial begin
    int waited;
    int drained;
    int expectedEdges;
    logic [31:0] rnd;
    logic [31:0] firstPc;
    logic offer;
    logic hold;
    dispatchGroup_t heldGroup;
    logic [BRANCH_CNT_W-1:0] heldBranches;
    logic [FETCH_WIDTH-1:0] sparseMasks [6];

    rst_i = 1'b1;
    flush_i = 1'b0;
    stall_i = 1'b0;
    decodeReady_i = 1'b0;
    fetchGroup = '0;
    seqNum = 32'h0000_0100;
    sparseMasks = '{8'b10100101, 8'b01011010, 8'b10000001, 8'b00110000,
                    8'b11111111, 8'b00000000};
    repeat (5) @(posedge clk);
    #2;
    rst_i = 1'b0;

    beginTest("reset");
    checkValue("ready after reset", cmpWord_t'(1'b0), cmpWord_t'(instBufferReady_o));
    checkValue("stall after reset", cmpWord_t'(1'b0), cmpWord_t'(stallFetch_o));
    checkValue("branches after reset", cmpWord_t'(0), cmpWord_t'(branchCount_o));
    reportTest();

    // sparse groups over many laps of the 32 entries
    beginTest("sparse");
    for (int c = 0; c < 48; c++) begin
      driveCycle(sparseMasks[c % 6], 1'b1, 1'b0, 1'b0);
    end
    waited = 0;
    while (instBufferReady_o && waited < 10) begin
      driveCycle('0, 1'b0, 1'b0, 1'b0);
      waited++;
    end
    if (instBufferReady_o) begin
      noteTimeout("the queue did not drain below four entries");
    end
    reportTest();

    beginTest("readyLevel");
    driveCycle('0, 1'b0, 1'b0, 1'b1);
    for (int c = 0; c < 3; c++) begin
      driveCycle(8'b00100000, 1'b1, 1'b0, 1'b0);
    end
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    checkValue("ready with three", cmpWord_t'(1'b0), cmpWord_t'(instBufferReady_o));
    driveCycle(8'b00000010, 1'b1, 1'b1, 1'b0);
    driveCycle('0, 1'b0, 1'b1, 1'b0);
    checkValue("ready with four", cmpWord_t'(1'b1), cmpWord_t'(instBufferReady_o));
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    checkValue("ready after dispatch", cmpWord_t'(1'b0), cmpWord_t'(instBufferReady_o));
    reportTest();

    // rename stalled while decode keeps offering full groups
    beginTest("backPressure");
    waited = 0;
    while (!stallFetch_o && waited < 10) begin
      driveCycle(8'hFF, 1'b1, 1'b1, 1'b0);
      waited++;
    end
    if (!stallFetch_o) begin
      noteTimeout("stallFetch_o never rose with rename stalled");
    end
    reportTest();

    beginTest("stallHold");
    heldGroup = lastExpect.group;
    heldBranches = lastExpect.branchCount;
    for (int c = 0; c < 5; c++) begin
      driveCycle(8'hFF, 1'b1, 1'b1, 1'b0);
      checkValue("held dispatchGroup_o", cmpWord_t'(heldGroup), cmpWord_t'(dispatchGroup_o));
      checkValue("held branchCount_o", cmpWord_t'(heldBranches), cmpWord_t'(branchCount_o));
      checkValue("stallFetch_o while full", cmpWord_t'(1'b1), cmpWord_t'(stallFetch_o));
    end
    // four leave per edge once rename lets go
    expectedEdges = int'(lastExpect.count) / DISPATCH_WIDTH;
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    drained = 0;
    while (instBufferReady_o && drained < 20) begin
      driveCycle('0, 1'b0, 1'b0, 1'b0);
      drained++;
    end
    if (instBufferReady_o) begin
      noteTimeout("the queue stayed ready after the stall was released");
    end
    checkValue("dispatch edges", cmpWord_t'(expectedEdges), cmpWord_t'(drained));
    reportTest();

    beginTest("flush");
    // fill past the stall level so that the flush has both flags to clear
    for (int c = 0; c < 4; c++) begin
      driveCycle(8'hFF, 1'b1, 1'b1, 1'b0);
    end
    // flush wins over the dispatch of the same edge
    driveCycle(8'hFF, 1'b1, 1'b0, 1'b1);
    driveCycle('0, 1'b0, 1'b1, 1'b0);
    checkValue("ready after flush", cmpWord_t'(1'b0), cmpWord_t'(instBufferReady_o));
    checkValue("stall after flush", cmpWord_t'(1'b0), cmpWord_t'(stallFetch_o));
    firstPc = seqNum;
    driveCycle(8'b11110000, 1'b1, 1'b1, 1'b0);
    driveCycle('0, 1'b0, 1'b1, 1'b0);
    checkValue("ready after refill", cmpWord_t'(1'b1), cmpWord_t'(instBufferReady_o));
    checkValue("head pc after flush", cmpWord_t'(firstPc),
               cmpWord_t'(dispatchGroup_o.entry[0].pc));
    reportTest();

    // random masks, fields, stalls and the odd flush
    beginTest("randomTraffic");
    for (int c = 0; c < 400; c++) begin
      rnd = randBits(8);
      offer = lfsrStep() | lfsrStep();
      hold = lfsrStep();
      firstPc = randBits(5);
      driveCycle(rnd[7:0], offer, hold, firstPc[4:0] == 5'd0);
    end
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    driveCycle('0, 1'b0, 1'b0, 1'b0);
    reportTest();

    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
design/decodedInstPkg.sv
design/fetchQueuePkg.sv
design/queueStorage.sv
design/queuePointers.sv
design/dispatchWindow.sv
design/instBuffer.sv
verification/instBufferTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = instBufferTb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
PASS_MSG = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only if the pass message shows up on a line of its own
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
